//--- uart_pkg.sv
// uart package
// register offsets, engine status words and AXI4-Lite channel bundles
`default_nettype none

package uart_pkg;

   // register byte offsets
   localparam logic [3:0] addr_txdata  = 4'h0;
   localparam logic [3:0] addr_rxdata  = 4'h4;
   localparam logic [3:0] addr_status  = 4'h8;
   localparam logic [3:0] addr_control = 4'hC;

   localparam logic [1:0] resp_okay = 2'b00;

   // receiver result, full means a byte is waiting
   typedef struct packed {
      logic [7:0] data;
      logic       full;
      logic       frame_err;
      logic       over_run;
   } rx_status_t;

   typedef struct packed {
      logic busy;
      logic over_run;
   } tx_status_t;

   // host driven channel signals
   typedef struct packed {
      logic        awvalid;
      logic [3:0]  awaddr;
      logic        wvalid;
      logic [31:0] wdata;
      logic        bready;
      logic        arvalid;
      logic [3:0]  araddr;
      logic        rready;
   } axil_req_t;

   // slave driven channel signals
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
// uart receiver
// oversampled start detection, mid-bit sampling, frame error and overrun flags
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
   parameter int sample_rate = 16
) (
   input  wire logic             rxclk,
   input  wire logic             reset,
   input  wire logic             rx_in,
   input  wire logic             rx_enable,
   input  wire logic             rx_unload,
   input  wire logic             status_clear,
   output uart_pkg::rx_status_t  rx_status
);

   localparam int cnt_w = (sample_rate > 2) ? $clog2(sample_rate) : 1;
   localparam logic [cnt_w-1:0] mid_cnt  = cnt_w'(sample_rate / 2);
   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(sample_rate - 1);

   logic             rx_d1;
   logic             rx_d2;
   logic             rx_busy;
   logic [cnt_w-1:0] sample_cnt;
   logic [3:0]       bit_cnt;
   logic [7:0]       shift_reg;
   logic [7:0]       rx_data;
   logic             full;
   logic             frame_err;
   logic             over_run;
   logic             mid_sample;
   logic             stop_sample;

   assign mid_sample  = rx_busy && (sample_cnt == mid_cnt);
   assign stop_sample = mid_sample && (bit_cnt == 4'd9);

   // two flop synchronizer, line idles high
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         rx_d1 <= 1'b1;
         rx_d2 <= 1'b1;
      end
      else
      begin
         rx_d1 <= rx_in;
         rx_d2 <= rx_d1;
      end
   end

   // frame sequencing, count 0 is the cycle the start edge was seen
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         rx_busy    <= 1'b0;
         sample_cnt <= '0;
         bit_cnt    <= '0;
      end
      else if (!rx_enable)
      begin
         rx_busy    <= 1'b0;
         sample_cnt <= '0;
         bit_cnt    <= '0;
      end
      else if (!rx_busy)
      begin
         if (!rx_d2)
         begin
            rx_busy    <= 1'b1;
            sample_cnt <= cnt_w'(1);
            bit_cnt    <= '0;
         end
      end
      else
      begin
         sample_cnt <= (sample_cnt == last_cnt) ? '0 : sample_cnt + 1'b1;
         if (mid_sample)
         begin
            if ((bit_cnt == 4'd0) && rx_d2)
               rx_busy <= 1'b0;   // start bit gone by mid-bit, a glitch
            else if (bit_cnt == 4'd9)
            begin
               rx_busy <= 1'b0;
               bit_cnt <= '0;
            end
            else
               bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge rxclk)
   begin
      if (mid_sample && (bit_cnt != 4'd0) && (bit_cnt != 4'd9))
         shift_reg <= {rx_d2, shift_reg[7:1]};
      if (stop_sample && rx_d2)
         rx_data <= shift_reg;
   end

   // result flags
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         full      <= 1'b0;
         frame_err <= 1'b0;
         over_run  <= 1'b0;
      end
      else
      begin
         if (status_clear)
         begin
            frame_err <= 1'b0;
            over_run  <= 1'b0;
         end
         if (rx_unload)
            full <= 1'b0;
         if (stop_sample)
         begin
            if (!rx_d2)
               frame_err <= 1'b1;
            else
            begin
               full <= 1'b1;
               // old byte overwritten before the host took it
               if (full && !rx_unload)
                  over_run <= 1'b1;
            end
         end
      end
   end

   assign rx_status = '{data: rx_data, full: full, frame_err: frame_err, over_run: over_run};

   a_bit_cnt_range: assert property (@(posedge rxclk) disable iff (reset)
      bit_cnt <= 4'd9);

   a_full_after_stop: assert property (@(posedge rxclk) disable iff (reset)
      $rose(full) |-> $past(stop_sample));

endmodule

`default_nettype wire

//--- uart_tx.sv
// uart transmitter
// bit rate divider and start/data/stop serializer with a holding register
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int sample_rate = 16
) (
   input  wire logic             rxclk,
   input  wire logic             reset,
   input  wire logic             tx_enable,
   input  wire logic             tx_load,
   input  wire logic [7:0]       tx_byte,
   input  wire logic             status_clear,
   output logic                  tx_out,
   output uart_pkg::tx_status_t  tx_status
);

   localparam int cnt_w = (sample_rate > 2) ? $clog2(sample_rate) : 1;
   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(sample_rate - 1);

   logic [cnt_w-1:0] div_cnt;
   logic             bit_tick;
   logic [3:0]       bit_cnt;
   logic [2:0]       data_idx;
   logic [7:0]       tx_reg;
   logic             busy;
   logic             over_run;

   assign bit_tick = tx_enable && (div_cnt == last_cnt);
   assign data_idx = bit_cnt[2:0] - 3'd1;

   // free running bit rate divider
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
         div_cnt <= '0;
      else if (!tx_enable || bit_tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // holding register
   always_ff @(posedge rxclk)
   begin
      if (tx_load && !busy)
         tx_reg <= tx_byte;
   end

   // 0 start, 1..8 data, 9 stop, 10 end of stop
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         tx_out   <= 1'b1;
         busy     <= 1'b0;
         bit_cnt  <= '0;
         over_run <= 1'b0;
      end
      else
      begin
         if (status_clear)
            over_run <= 1'b0;
         if (tx_load)
         begin
            if (busy)
               over_run <= 1'b1;
            else
               busy <= 1'b1;
         end
         if (!tx_enable)
         begin
            bit_cnt <= '0;
            tx_out  <= 1'b1;
         end
         else if (busy && bit_tick)
         begin
            bit_cnt <= bit_cnt + 4'd1;
            case (bit_cnt)
               4'd0:    tx_out <= 1'b0;
               4'd9:    tx_out <= 1'b1;
               4'd10:
               begin
                  busy    <= 1'b0;
                  bit_cnt <= '0;
               end
               default: tx_out <= tx_reg[data_idx];
            endcase
         end
      end
   end

   assign tx_status = '{busy: busy, over_run: over_run};

   a_idle_high: assert property (@(posedge rxclk) disable iff (reset)
      !busy |-> tx_out);

endmodule

`default_nettype wire

//--- uart_regs.sv
// uart register block
// AXI4-Lite slave with tx data, rx data, status and control registers
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
   input  wire logic             rxclk,
   input  wire logic             reset,
   input  wire uart_pkg::axil_req_t axil_req,
   input  wire uart_pkg::rx_status_t rx_status,
   input  wire uart_pkg::tx_status_t tx_status,
   output uart_pkg::axil_rsp_t   axil_rsp,
   output logic                  tx_enable,
   output logic                  rx_enable,
   output logic                  tx_load,
   output logic [7:0]            tx_byte,
   output logic                  rx_unload,
   output logic                  status_clear
);

   import uart_pkg::*;

   logic        wr_ready;   // awready and wready together
   logic        bvalid;
   logic        rd_ready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [31:0] status_word;
   logic [31:0] rd_mux;

   assign status_word = {27'd0,
                         tx_status.over_run,
                         rx_status.over_run,
                         rx_status.frame_err,
                         rx_status.full,
                         tx_status.busy};

   // read decode, txdata and unmapped offsets read zero
   always_comb
   begin
      case (axil_req.araddr)
         addr_rxdata:  rd_mux = {24'd0, rx_status.data};
         addr_status:  rd_mux = status_word;
         addr_control: rd_mux = {30'd0, rx_enable, tx_enable};
         default:      rd_mux = '0;
      endcase
   end

   // write channel and control register
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ready  <= 1'b0;
         bvalid    <= 1'b0;
         tx_enable <= 1'b0;
         rx_enable <= 1'b0;
      end
      else
      begin
         wr_ready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_ready;
         if (wr_ready)
            bvalid <= 1'b1;
         else if (axil_req.bready)
            bvalid <= 1'b0;
         if (wr_ready && (axil_req.awaddr == addr_control))
         begin
            tx_enable <= axil_req.wdata[0];
            rx_enable <= axil_req.wdata[1];
         end
      end
   end

   // read channel
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         rd_ready <= 1'b0;
         rvalid   <= 1'b0;
      end
      else
      begin
         rd_ready <= axil_req.arvalid && !rvalid && !rd_ready;
         if (rd_ready)
            rvalid <= 1'b1;
         else if (axil_req.rready)
            rvalid <= 1'b0;
      end
   end

   // read data captured in the accept cycle, held until rready
   always_ff @(posedge rxclk)
   begin
      if (rd_ready)
         rdata <= rd_mux;
   end

   // side effects fire in the accept cycle
   assign tx_load      = wr_ready && (axil_req.awaddr == addr_txdata);
   assign tx_byte      = axil_req.wdata[7:0];
   assign rx_unload    = rd_ready && (axil_req.araddr == addr_rxdata);
   assign status_clear = rd_ready && (axil_req.araddr == addr_status);

   assign axil_rsp = '{awready: wr_ready,
                       wready:  wr_ready,
                       bvalid:  bvalid,
                       bresp:   resp_okay,
                       arready: rd_ready,
                       rvalid:  rvalid,
                       rdata:   rdata,
                       rresp:   resp_okay};

   a_bvalid_hold: assert property (@(posedge rxclk) disable iff (reset)
      bvalid && !axil_req.bready |=> bvalid);

   a_rvalid_hold: assert property (@(posedge rxclk) disable iff (reset)
      rvalid && !axil_req.rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- uart_top.sv
// uart top level
// AXI4-Lite register block driving the receiver and transmitter engines
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
   parameter int sample_rate = 16
) (
   input  wire logic                rxclk,
   input  wire logic                reset,
   input  wire uart_pkg::axil_req_t axil_req,
   input  wire logic                rx_in,
   output wire uart_pkg::axil_rsp_t axil_rsp,
   output wire logic                tx_out
);

   import uart_pkg::*;

   logic       tx_enable;
   logic       rx_enable;
   logic       tx_load;
   logic [7:0] tx_byte;
   logic       rx_unload;
   logic       status_clear;
   rx_status_t rx_status;
   tx_status_t tx_status;

   uart_regs u_regs (
      .rxclk        (rxclk),
      .reset        (reset),
      .axil_req     (axil_req),
      .rx_status    (rx_status),
      .tx_status    (tx_status),
      .axil_rsp     (axil_rsp),
      .tx_enable    (tx_enable),
      .rx_enable    (rx_enable),
      .tx_load      (tx_load),
      .tx_byte      (tx_byte),
      .rx_unload    (rx_unload),
      .status_clear (status_clear)
   );

   uart_rx #(
      .sample_rate (sample_rate)
   ) u_rx (
      .rxclk        (rxclk),
      .reset        (reset),
      .rx_in        (rx_in),
      .rx_enable    (rx_enable),
      .rx_unload    (rx_unload),
      .status_clear (status_clear),
      .rx_status    (rx_status)
   );

   uart_tx #(
      .sample_rate (sample_rate)
   ) u_tx (
      .rxclk        (rxclk),
      .reset        (reset),
      .tx_enable    (tx_enable),
      .tx_load      (tx_load),
      .tx_byte      (tx_byte),
      .status_clear (status_clear),
      .tx_out       (tx_out),
      .tx_status    (tx_status)
   );

endmodule

`default_nettype wire

//--- tb_uart.sv
// uart testbench
// random bytes through the AXI4-Lite port, serial line model and tx_out decoder
`timescale 1ns/1ps
`default_nettype none

module tb_uart;

   import uart_pkg::*;

   localparam int sample_rate  = 16;
   localparam int frame_cycles = 10 * sample_rate;
   // twice about 40 frames plus register traffic per frame
   localparam int max_cycles   = 2 * 40 * (frame_cycles + 90);

   logic       rxclk;
   logic       reset;
   axil_req_t  axil_req;
   axil_rsp_t  axil_rsp;
   logic       tx_out;
   wire        rx_in;
   logic       loopback;
   logic       line_drv;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   logic [7:0] tx_q[$];

   assign rx_in = loopback ? tx_out : line_drv;

   uart_top #(
      .sample_rate (sample_rate)
   ) UUT (
      .rxclk    (rxclk),
      .reset    (reset),
      .axil_req (axil_req),
      .rx_in    (rx_in),
      .axil_rsp (axil_rsp),
      .tx_out   (tx_out)
   );

   initial
   begin
      rxclk = 1'b0;
      forever #50 rxclk = ~rxclk;
   end

   initial
   begin : watchdog
      while (cycles < max_cycles)
      begin
         @(posedge rxclk);
         cycles = cycles + 1;
      end
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
      checks++;
      assert (got === exp_val)
      else
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h",
                  $time, name, exp_val, got);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         errors++;
         $display("ERROR at %0t: %s", $time, what);
      end
   endtask

   // valids held through the cycle after ready shows up
   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
      @(negedge rxclk);
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      @(negedge rxclk);
      while (!axil_rsp.awready)
         @(negedge rxclk);
      check_value("wready", {31'd0, axil_rsp.wready}, 32'd1);
      @(negedge rxclk);
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      while (!axil_rsp.bvalid)
         @(negedge rxclk);
      check_value("bresp", 32'(axil_rsp.bresp), 32'(resp_okay));
      axil_req.bready = 1'b1;
      @(negedge rxclk);
      axil_req.bready = 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
      @(negedge rxclk);
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      @(negedge rxclk);
      while (!axil_rsp.arready)
         @(negedge rxclk);
      @(negedge rxclk);
      axil_req.arvalid = 1'b0;
      while (!axil_rsp.rvalid)
         @(negedge rxclk);
      check_value("rresp", 32'(axil_rsp.rresp), 32'(resp_okay));
      data = axil_rsp.rdata;
      axil_req.rready = 1'b1;
      @(negedge rxclk);
      axil_req.rready = 1'b0;
   endtask

   task automatic wait_tx_idle();
      logic [31:0] st;
      axi_read(addr_status, st);
      while (st[0])
         axi_read(addr_status, st);
   endtask

   task automatic wait_rx_full();
      logic [31:0] st;
      axi_read(addr_status, st);
      while (!st[1])
         axi_read(addr_status, st);
   endtask

   // one frame on the line, then one idle bit
   task automatic send_frame(input logic [7:0] data, input logic stop);
      @(negedge rxclk);
      line_drv = 1'b0;
      repeat (sample_rate) @(negedge rxclk);
      for (int i = 0; i < 8; i++)
      begin
         line_drv = data[i];
         repeat (sample_rate) @(negedge rxclk);
      end
      line_drv = stop;
      repeat (sample_rate) @(negedge rxclk);
      line_drv = 1'b1;
      repeat (sample_rate) @(negedge rxclk);
   endtask

   // tx_out decoder sampling each bit at its middle
   initial
   begin : tx_decoder
      logic [7:0] got;
      logic [7:0] exp_byte;
      forever
      begin
         @(negedge rxclk);
         if (!reset && (tx_out === 1'b0))
         begin
            repeat (sample_rate / 2) @(negedge rxclk);
            check_true(!tx_out, "tx_out start bit ended before mid-bit");
            for (int i = 0; i < 8; i++)
            begin
               repeat (sample_rate) @(negedge rxclk);
               got[i] = tx_out;
            end
            repeat (sample_rate) @(negedge rxclk);
            check_true(tx_out, "tx_out stop bit is low");
            if (tx_q.size() == 0)
               check_true(1'b0, $sformatf("tx_out sent byte 0x%0h nobody wrote", got));
            else
            begin
               exp_byte = tx_q.pop_front();
               check_value("tx_out byte", {24'd0, got}, {24'd0, exp_byte});
            end
         end
      end
   end

   initial
   begin : stimulus
      int unsigned seed;
      logic [7:0]  b;
      logic [7:0]  b2;
      logic [31:0] rd;
      reset    = 1'b1;
      axil_req = '0;
      loopback = 1'b0;
      line_drv = 1'b1;
      seed     = $urandom(97308);
      repeat (2) @(posedge rxclk);
      @(negedge rxclk);
      reset = 1'b0;

      // reset state
      check_value("tx_out", {31'd0, tx_out}, 32'd1);
      axi_read(addr_status, rd);
      check_value("status", rd, 32'd0);
      axi_read(addr_control, rd);
      check_value("control", rd, 32'd0);

      // transmit format
      axi_write(addr_control, 32'd1);
      repeat (20)
      begin
         b = 8'($urandom);
         wait_tx_idle();
         tx_q.push_back(b);
         axi_write(addr_txdata, {24'd0, b});
      end
      wait_tx_idle();
      check_value("tx queue size", 32'(tx_q.size()), 32'd0);

      // loopback receive
      loopback = 1'b1;
      axi_write(addr_control, 32'd3);
      for (int n = 0; n < 10; n++)
      begin
         b = 8'($urandom);
         tx_q.push_back(b);
         axi_write(addr_txdata, {24'd0, b});
         wait_rx_full();
         axi_read(addr_rxdata, rd);
         check_value("rxdata", rd, {24'd0, b});
         axi_read(addr_status, rd);
         check_value("status full", {31'd0, rd[1]}, 32'd0);
         wait_tx_idle();
      end
      loopback = 1'b0;

      // frame error cleared by the status read
      send_frame(8'($urandom), 1'b0);
      axi_read(addr_status, rd);
      check_value("status after low stop bit", rd, 32'h4);
      axi_read(addr_status, rd);
      check_value("status after clear", rd, 32'd0);

      // rx overrun keeps the newer byte
      b  = 8'($urandom);
      b2 = 8'($urandom);
      send_frame(b, 1'b1);
      send_frame(b2, 1'b1);
      axi_read(addr_status, rd);
      check_value("status after two frames", rd, 32'ha);
      axi_read(addr_rxdata, rd);
      check_value("rxdata after overrun", rd, {24'd0, b2});
      axi_read(addr_status, rd);
      check_value("status after unload", rd, 32'd0);

      // tx overrun drops the second byte
      b = 8'($urandom);
      tx_q.push_back(b);
      axi_write(addr_txdata, {24'd0, b});
      axi_write(addr_txdata, {24'd0, ~b});
      axi_read(addr_status, rd);
      check_value("status with tx overrun", rd, 32'h11);
      wait_tx_idle();
      check_value("tx queue size", 32'(tx_q.size()), 32'd0);

      // enable gating
      axi_write(addr_control, 32'd1);
      send_frame(8'($urandom), 1'b1);
      axi_read(addr_status, rd);
      check_value("status with rx disabled", rd, 32'd0);
      axi_write(addr_control, 32'd2);
      b = 8'($urandom);
      tx_q.push_back(b);
      axi_write(addr_txdata, {24'd0, b});
      repeat (2 * frame_cycles) @(negedge rxclk);
      check_value("tx queue size while disabled", 32'(tx_q.size()), 32'd1);
      check_value("tx_out while disabled", {31'd0, tx_out}, 32'd1);
      axi_write(addr_control, 32'd1);
      wait_tx_idle();
      check_value("tx queue size after enable", 32'(tx_q.size()), 32'd0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_top.sv
tb_uart.sv

//--- Makefile
TOP = tb_uart

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

lint:
	verilator --lint-only -Wall --timing --top-module uart_top -f project.f

clean:
	rm -rf obj_dir
